//--- compile.f
common/isa_pkg.sv
common/rob_pkg.sv
design/completion_queue.sv
design/alu_unit.sv
design/lsu_unit.sv
rob/rob.sv
design/rob_subsystem.sv
testbench/rob_properties.sv
testbench/tb_rob_subsystem.sv

//--- Makefile
TOP = tb_rob_subsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/rob_tests.txt
// test op rd src_a src_b imm pc pred expected flags
// flags: 1 squashed by a mispredict, 2 wait until all earlier operations retired
1 0 01 5 7 0 0 0 c 0
1 1 02 3 5 0 0 0 fffffffe 0
1 2 03 f0f0 ff00 0 0 0 f000 0
1 5 06 ffffffff 1 0 0 0 1 0
1 6 00 3 3 40 10 1 1 0
3 9 07 10 deadbeef 4 0 0 deadbeef 0
3 8 08 10 0 4 0 0 deadbeef 2
3 9 00 20 12345678 0 0 0 12345678 0
2 8 09 20 0 0 0 0 12345678 2
2 0 0a 1 2 0 0 0 3 0
2 1 0b a 4 0 0 0 6 0
2 4 0c 5 3 0 0 0 6 0
4 6 00 4 4 40 100 0 1 0
4 0 0d 1 1 0 0 0 2 1
4 9 00 10 bad 4 0 0 bad 1
4 8 0e 10 0 4 0 0 deadbeef 2
5 8 0f 20 0 0 0 0 12345678 2
5 0 10 1 1 0 0 0 2 0
5 0 11 2 2 0 0 0 4 0
5 0 12 3 3 0 0 0 6 0
5 0 13 4 4 0 0 0 8 0
5 0 14 5 5 0 0 0 a 0
5 0 15 6 6 0 0 0 c 0
5 0 16 7 7 0 0 0 e 0
5 0 17 8 8 0 0 0 10 0
5 0 18 9 9 0 0 0 12 0
0 0 0 0 0 0 0 0 0 0 // end of list

//--- testbench/tb_rob_subsystem.sv
module tb_rob_subsystem import isa_pkg::*, rob_pkg::*; ();
    localparam int clk_period = 4;
    localparam int fields     = 10; // words per operation line
    localparam int max_ops    = 100;

    logic              clk = 1'b0;
    logic              rst;
    logic              rdy;
    logic              dispatch_valid;
    logic              dispatch_ready;
    opcode_t           opcode;
    reg_name_t         rd;
    logic [data_w-1:0] src_a;
    logic [data_w-1:0] src_b;
    logic [data_w-1:0] imm;
    logic [data_w-1:0] pc;
    logic              predicted_taken;
    logic              retire_valid;
    tag_t              retire_tag;
    reg_name_t         retire_rd;
    logic [data_w-1:0] retire_data;
    logic              flush;
    logic [data_w-1:0] redirect_pc;

    logic [31:0] ops [fields*max_ops];
    int          n_ops;
    int          sent_live = 0; // accepted and not squashed
    int          cur_test = 0;
    int          retired_n = 0;
    int          outstanding = 0;
    int          exp_idx = 0;
    int          exp_tag = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    logic        accepted_last = 1'b0;
    logic        clear_pending = 1'b0;
    logic        reset_checked = 1'b0;
    logic        stall_seen = 1'b0;

    always #(clk_period / 2) clk = ~clk;

    rob_subsystem #(
        .rob_depth(rob_depth)
    ) dut_i (
        .clk            (clk),
        .rst            (rst),
        .rdy            (rdy),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .opcode         (opcode),
        .rd             (rd),
        .src_a          (src_a),
        .src_b          (src_b),
        .imm            (imm),
        .pc             (pc),
        .predicted_taken(predicted_taken),
        .retire_valid   (retire_valid),
        .retire_tag     (retire_tag),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .flush          (flush),
        .redirect_pc    (redirect_pc)
    );

    function automatic string group_name(input int id);
        case (id)
            1:       return "int_ops";
            2:       return "load_first";
            3:       return "store_load";
            4:       return "mispredict";
            5:       return "rob_full";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_field(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        string name;
        name = group_name(ops[exp_idx * fields]);
        assert (actual === expected)
        else begin
            value_errors++;
            $display("error %s op %0d %s: expected %h actual %h",
                     name, exp_idx, field, expected, actual);
        end
    endtask

    task automatic check_retirement();
        int          b;
        opcode_t     op;
        logic [31:0] expected;
        logic        taken;
        logic        exp_flush;
        logic [31:0] exp_pc;
        while (exp_idx < n_ops && ops[exp_idx * fields + 9][0])
            exp_idx++;
        if (exp_idx >= n_ops) begin
            other_errors++;
            $display("retirement with tag %0d after the last expected operation", retire_tag);
            return;
        end
        b         = exp_idx * fields;
        op        = opcode_t'(ops[b + 1][3:0]);
        expected  = ops[b + 8];
        taken     = expected[0]; // branches retire their direction
        exp_flush = (op == op_beq || op == op_bne) && (ops[b + 7][0] != taken);
        exp_pc    = taken ? ops[b + 6] + ops[b + 5] : ops[b + 6] + 32'd4;
        check_field("tag", 32'(exp_tag), 32'(retire_tag));
        check_field("rd", (op == op_sw) ? 32'd0 : 32'(ops[b + 2][4:0]), 32'(retire_rd));
        check_field("data", expected, retire_data);
        check_field("flush", 32'(exp_flush), 32'(flush));
        if (exp_flush)
            check_field("redirect_pc", exp_pc, redirect_pc);
        exp_tag = exp_flush ? 0 : (exp_tag + 1) % rob_depth; // tags restart after flush
        exp_idx++;
    endtask

    // retire monitor and stall check, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (!reset_checked) begin
                assert (dispatch_ready && !retire_valid && !flush)
                else begin
                    other_errors++;
                    $display("outputs not in their idle state after reset");
                end
                reset_checked = 1'b1;
            end
            if (clear_pending)
                outstanding = 0;
            else if (accepted_last)
                outstanding++;
            clear_pending = 1'b0;
            if (retire_valid) begin
                outstanding--;
                retired_n++;
                check_retirement();
                clear_pending = flush;
            end else begin
                assert (!flush)
                else begin
                    other_errors++;
                    $display("flush raised without a retirement");
                end
            end
            if (dispatch_valid && !dispatch_ready) begin
                stall_seen = 1'b1;
                assert (outstanding == rob_depth)
                else begin
                    value_errors++;
                    $display("error %s dispatch stall: expected %0d outstanding actual %0d",
                             group_name(cur_test), rob_depth, outstanding);
                end
            end
            accepted_last = dispatch_valid && dispatch_ready;
        end
    end

    task automatic dispatch_op(input int i);
        int b;
        b = i * fields;
        if (ops[b + 9][1]) begin
            wait (retired_n == sent_live);
            @(posedge clk);
            #1;
        end
        cur_test        = ops[b];
        opcode          = opcode_t'(ops[b + 1][3:0]);
        rd              = ops[b + 2][4:0];
        src_a           = ops[b + 3];
        src_b           = ops[b + 4];
        imm             = ops[b + 5];
        pc              = ops[b + 6];
        predicted_taken = ops[b + 7][0];
        dispatch_valid  = 1'b1;
        @(negedge clk);
        while (!dispatch_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        if (!ops[b + 9][0])
            sent_live++;
    endtask

    initial begin
        rst             = 1'b1;
        rdy             = 1'b1;
        dispatch_valid  = 1'b0;
        opcode          = op_add;
        rd              = '0;
        src_a           = '0;
        src_b           = '0;
        imm             = '0;
        pc              = '0;
        predicted_taken = 1'b0;
        $readmemh("testbench/rob_tests.txt", ops);
        n_ops = 0;
        while (n_ops < max_ops && ops[n_ops * fields] != 0)
            n_ops++;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_ops; i++)
            dispatch_op(i);
        wait (retired_n == sent_live);
        repeat (20) @(posedge clk); // late or squashed retirements show up here
        if (n_ops == 0)
            $display("no operations read from the data file");
        if (!stall_seen) begin
            other_errors++;
            $display("dispatch never stalled on a full reorder buffer");
        end
        $display("checks done: %0d value errors, %0d other errors, %0d property failures",
                 value_errors, other_errors, dut_i.rob_i.props_i.fail_count);
        if (n_ops > 0 && value_errors == 0 && other_errors == 0 &&
            dut_i.rob_i.props_i.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #1;
        #(n_ops * 40 * clk_period);
        $display("watchdog: run did not finish within %0d cycles", n_ops * 40);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- testbench/rob_properties.sv
module rob_properties (
    input logic       clk,
    input logic       rst,
    input logic       retire_valid,
    input logic [4:0] retire_rd,
    input logic       store_commit,
    input logic       flush
);
    int fail_count = 0; // read by the testbench at the end

    assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
    else begin
        fail_count++;
        $error("flush held high for two cycles");
    end

    assert property (@(posedge clk) rst |=> !retire_valid)
    else begin
        fail_count++;
        $error("retire_valid high during reset");
    end

    // a commit only comes with a store retiring, and stores write no register
    assert property (@(posedge clk) disable iff (rst)
                     store_commit |-> retire_valid && (retire_rd == '0))
    else begin
        fail_count++;
        $error("store commit without a store retirement");
    end

endmodule

bind rob rob_properties props_i (
    .clk         (clk),
    .rst         (rst),
    .retire_valid(retire_valid),
    .retire_rd   (retire_rd),
    .store_commit(store_commit),
    .flush       (flush)
);

//--- design/rob_subsystem.sv
module rob_subsystem import isa_pkg::*, rob_pkg::*; #(
    parameter int rob_depth = rob_pkg::rob_depth
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              dispatch_valid,
    output logic              dispatch_ready,
    input  opcode_t           opcode,
    input  reg_name_t         rd,
    input  logic [data_w-1:0] src_a,
    input  logic [data_w-1:0] src_b,
    input  logic [data_w-1:0] imm,
    input  logic [data_w-1:0] pc,
    input  logic              predicted_taken,
    output logic              retire_valid,
    output tag_t              retire_tag,
    output reg_name_t         retire_rd,
    output logic [data_w-1:0] retire_data,
    output logic              flush,
    output logic [data_w-1:0] redirect_pc
);
    localparam int queue_depth = 4;

    op_class_t   cls;
    logic        to_alu;
    logic        accept;
    logic        alu_ready;
    logic        lsu_ready;
    logic        rob_full;
    tag_t        alloc_tag;
    logic        alu_valid;
    logic        alu_pop;
    alu_result_t alu_result;
    logic        mem_valid;
    logic        mem_pop;
    mem_result_t mem_result;
    logic        store_commit;
    tag_t        store_commit_tag;

    assign cls            = op_class(opcode);
    assign to_alu         = (cls == cls_int) || (cls == cls_branch);
    assign dispatch_ready = !rob_full && (to_alu ? alu_ready : lsu_ready);
    assign accept         = dispatch_valid && dispatch_ready;

    rob #(
        .rob_depth(rob_depth)
    ) rob_i (
        .clk             (clk),
        .rst             (rst),
        .rdy             (rdy),
        .alloc           (accept),
        .alloc_rd        (rd),
        .alloc_pred_taken(predicted_taken && (cls == cls_branch)),
        .alloc_is_store  (cls == cls_store),
        .alloc_tag       (alloc_tag),
        .full            (rob_full),
        .alu_valid       (alu_valid),
        .alu_result      (alu_result),
        .alu_pop         (alu_pop),
        .mem_valid       (mem_valid),
        .mem_result      (mem_result),
        .mem_pop         (mem_pop),
        .retire_valid    (retire_valid),
        .retire_tag      (retire_tag),
        .retire_rd       (retire_rd),
        .retire_data     (retire_data),
        .flush           (flush),
        .redirect_pc     (redirect_pc),
        .store_commit    (store_commit),
        .store_commit_tag(store_commit_tag)
    );

    alu_unit #(
        .queue_depth(queue_depth),
        .tag_t      (tag_t)
    ) alu_i (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .flush       (flush),
        .issue_valid (accept && to_alu),
        .issue_tag   (alloc_tag),
        .opcode      (opcode),
        .src_a       (src_a),
        .src_b       (src_b),
        .imm         (imm),
        .pc          (pc),
        .pop         (alu_pop),
        .issue_ready (alu_ready),
        .result_valid(alu_valid),
        .result      (alu_result)
    );

    lsu_unit #(
        .queue_depth(queue_depth)
    ) lsu_i (
        .clk             (clk),
        .rst             (rst),
        .rdy             (rdy),
        .flush           (flush),
        .issue_valid     (accept && !to_alu),
        .issue_tag       (alloc_tag),
        .is_store        (cls == cls_store),
        .base            (src_a),
        .store_data      (src_b),
        .offset          (imm),
        .pop             (mem_pop),
        .store_commit    (store_commit),
        .store_commit_tag(store_commit_tag),
        .issue_ready     (lsu_ready),
        .result_valid    (mem_valid),
        .result          (mem_result)
    );

endmodule

//--- rob/rob.sv
module rob import isa_pkg::*, rob_pkg::*; #(
    parameter int rob_depth = rob_pkg::rob_depth
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              alloc,
    input  reg_name_t         alloc_rd,
    input  logic              alloc_pred_taken,
    input  logic              alloc_is_store,
    output tag_t              alloc_tag,
    output logic              full,
    input  logic              alu_valid,
    input  alu_result_t       alu_result,
    output logic              alu_pop,
    input  logic              mem_valid,
    input  mem_result_t       mem_result,
    output logic              mem_pop,
    output logic              retire_valid,
    output tag_t              retire_tag,
    output reg_name_t         retire_rd,
    output logic [data_w-1:0] retire_data,
    output logic              flush,
    output logic [data_w-1:0] redirect_pc,
    output logic              store_commit,
    output tag_t              store_commit_tag
);
    logic [rob_depth-1:0]           done;
    reg_name_t                      rd_q [rob_depth];
    logic [data_w-1:0]              value_q [rob_depth];
    logic [data_w-1:0]              target_q [rob_depth];
    logic [rob_depth-1:0]           pred_q;
    logic [rob_depth-1:0]           taken_q;
    logic [rob_depth-1:0]           store_q;
    tag_t                           head;
    tag_t                           tail;
    logic [$clog2(rob_depth+1)-1:0] count;
    logic                           alloc_fire;
    logic                           retire_fire;
    logic                           mispredict;

    function automatic tag_t wrap_inc(input tag_t p);
        return (p == tag_t'(rob_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign alloc_tag   = tail;
    assign full        = (count == rob_depth);
    assign alloc_fire  = rdy && alloc && !full;
    assign retire_fire = rdy && !flush && (count != 0) && done[head];
    assign mispredict  = !store_q[head] && (pred_q[head] != taken_q[head]);

    // one write-back per cycle, integer queue first
    assign alu_pop = rdy && alu_valid;
    assign mem_pop = rdy && mem_valid && !alu_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            retire_valid <= 1'b0;
            flush        <= 1'b0;
            store_commit <= 1'b0;
        end else if (rdy) begin
            retire_valid <= retire_fire;
            store_commit <= retire_fire && store_q[head];
            flush        <= retire_fire && mispredict; // retire_fire is low while flushing
            if (flush) begin
                head  <= '0;
                tail  <= '0;
                count <= '0;
                done  <= '0;
            end else begin
                if (alloc_fire) begin
                    tail       <= wrap_inc(tail);
                    done[tail] <= 1'b0;
                end
                if (alu_pop)
                    done[alu_result.tag] <= 1'b1;
                if (mem_pop)
                    done[mem_result.tag] <= 1'b1;
                if (retire_fire)
                    head <= wrap_inc(head);
                if (alloc_fire && !retire_fire)
                    count <= count + 1'b1;
                else if (!alloc_fire && retire_fire)
                    count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rd_q[tail]    <= alloc_is_store ? '0 : alloc_rd;
            pred_q[tail]  <= alloc_pred_taken;
            store_q[tail] <= alloc_is_store;
        end
        if (alu_pop) begin
            value_q[alu_result.tag]  <= alu_result.value;
            taken_q[alu_result.tag]  <= alu_result.taken;
            target_q[alu_result.tag] <= alu_result.target;
        end
        if (mem_pop) begin
            value_q[mem_result.tag] <= mem_result.value;
            taken_q[mem_result.tag] <= 1'b0;
        end
        if (retire_fire) begin
            retire_tag       <= head;
            retire_rd        <= rd_q[head];
            retire_data      <= value_q[head];
            redirect_pc      <= target_q[head];
            store_commit_tag <= head;
        end
    end

endmodule

//--- design/lsu_unit.sv
module lsu_unit import isa_pkg::*, rob_pkg::*; #(
    parameter int queue_depth = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              flush,
    input  logic              issue_valid,
    input  tag_t              issue_tag,
    input  logic              is_store,
    input  logic [data_w-1:0] base,
    input  logic [data_w-1:0] store_data,
    input  logic [data_w-1:0] offset,
    input  logic              pop,
    input  logic              store_commit,
    input  tag_t              store_commit_tag,
    output logic              issue_ready,
    output logic              result_valid,
    output mem_result_t       result
);
    localparam int mem_words = 64;
    localparam int tbl_size  = 2 ** $bits(tag_t);

    logic [data_w-1:0]   mem [mem_words];
    logic [5:0]          st_addr [tbl_size];  // held stores, by rob tag
    logic [data_w-1:0]   st_data [tbl_size];
    logic [tbl_size-1:0] st_valid;

    logic              s1_valid;
    logic              s1_store;
    tag_t              s1_tag;
    logic [5:0]        s1_addr;
    logic [data_w-1:0] s1_data;
    logic              s2_valid;
    mem_result_t       s2;

    logic              q_full;
    logic              advance;
    logic              accept;
    logic              s1_direct;
    logic              q_push;
    mem_result_t       q_data;
    logic [data_w-1:0] ea;

    assign ea          = base + offset;
    assign advance     = rdy && !q_full; // whole pipe stalls on a full queue
    assign issue_ready = !q_full;
    assign accept      = advance && issue_valid;
    // store skips the memory stage when no load sits there
    assign s1_direct   = s1_valid && s1_store && !s2_valid;
    assign q_push      = advance && (s2_valid || s1_direct);
    assign q_data      = s2_valid ? s2 : mem_result_t'{s1_tag, s1_data};

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            st_valid <= '0;
        end else if (rdy) begin
            if (flush) begin
                s1_valid <= 1'b0;
                s2_valid <= 1'b0;
                st_valid <= '0;
            end else begin
                if (store_commit)
                    st_valid[store_commit_tag] <= 1'b0;
                if (accept && is_store)
                    st_valid[issue_tag] <= 1'b1; // tag may be reused right away
                if (advance) begin
                    s1_valid <= issue_valid;
                    s2_valid <= s1_valid && !s1_direct;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_tag   <= issue_tag;
            s1_store <= is_store;
            s1_addr  <= ea[7:2];
            s1_data  <= store_data;
        end
        if (accept && is_store) begin
            st_addr[issue_tag] <= ea[7:2];
            st_data[issue_tag] <= store_data;
        end
        if (advance) begin
            s2.tag   <= s1_tag;
            s2.value <= s1_store ? s1_data : mem[s1_addr]; // loads see memory as it is now
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_words; i++)
                mem[i] <= '0;
        end else if (rdy && store_commit && st_valid[store_commit_tag]) begin
            mem[st_addr[store_commit_tag]] <= st_data[store_commit_tag];
        end
    end

    completion_queue #(
        .payload_t(mem_result_t),
        .depth    (queue_depth)
    ) queue_i (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush && rdy),
        .push     (q_push),
        .push_data(q_data),
        .pop      (pop),
        .full     (q_full),
        .valid    (result_valid),
        .head     (result)
    );

endmodule

//--- design/alu_unit.sv
module alu_unit import isa_pkg::*, rob_pkg::*; #(
    parameter int  queue_depth = 4,
    parameter type tag_t       = logic [2:0]
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              flush,
    input  logic              issue_valid,
    input  tag_t              issue_tag,
    input  opcode_t           opcode,
    input  logic [data_w-1:0] src_a,
    input  logic [data_w-1:0] src_b,
    input  logic [data_w-1:0] imm,
    input  logic [data_w-1:0] pc,
    input  logic              pop,
    output logic              issue_ready,
    output logic              result_valid,
    output alu_result_t       result
);
    alu_result_t       stage;
    logic              stage_valid;
    logic              q_full;
    logic              q_push;
    logic [data_w-1:0] value;
    logic              taken;

    always_comb begin
        value = '0;
        taken = 1'b0;
        case (opcode)
            op_add: value = src_a + src_b;
            op_sub: value = src_a - src_b;
            op_and: value = src_a & src_b;
            op_or:  value = src_a | src_b;
            op_xor: value = src_a ^ src_b;
            op_slt: value = data_w'($signed(src_a) < $signed(src_b));
            op_beq: taken = (src_a == src_b);
            op_bne: taken = (src_a != src_b);
            default: ;
        endcase
        if (opcode inside {op_beq, op_bne})
            value = data_w'(taken); // branches report their direction
    end

    // stage drains into the queue unless it is full
    assign issue_ready = !stage_valid || !q_full;
    assign q_push      = rdy && stage_valid && !q_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (rdy) begin
            if (flush)
                stage_valid <= 1'b0;
            else if (issue_ready)
                stage_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issue_valid && issue_ready) begin
            stage.tag    <= issue_tag;
            stage.value  <= value;
            stage.taken  <= taken;
            stage.target <= taken ? pc + imm : pc + data_w'(4);
        end
    end

    completion_queue #(
        .payload_t(alu_result_t),
        .depth    (queue_depth)
    ) queue_i (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush && rdy),
        .push     (q_push),
        .push_data(stage),
        .pop      (pop),
        .full     (q_full),
        .valid    (result_valid),
        .head     (result)
    );

endmodule

//--- design/completion_queue.sv
module completion_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     full,
    output logic     valid,
    output payload_t head
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    payload_t                   entries [depth];
    logic [ptr_w-1:0]           rd_ptr;
    logic [ptr_w-1:0]           wr_ptr;
    logic [$clog2(depth+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == depth);
    assign valid   = (count != 0);
    assign head    = entries[rd_ptr];
    assign do_push = push && !full; // producers check full first
    assign do_pop  = pop && valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (!do_push && do_pop)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            entries[wr_ptr] <= push_data;
    end

endmodule

//--- common/rob_pkg.sv
package rob_pkg;

    localparam int rob_depth = 8;

    typedef logic [2:0] tag_t;

    // integer and branch completion
    typedef struct packed {
        tag_t                        tag;
        logic [isa_pkg::data_w-1:0] value;
        logic                        taken;  // resolved direction
        logic [isa_pkg::data_w-1:0] target; // resolved next pc
    } alu_result_t;

    // load data, or store data for stores
    typedef struct packed {
        tag_t                        tag;
        logic [isa_pkg::data_w-1:0] value;
    } mem_result_t;

endpackage

//--- common/isa_pkg.sv
package isa_pkg;

    localparam int data_w = 32;

    typedef logic [4:0] reg_name_t; // x0 means no write

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_beq,
        op_bne,
        op_lw,
        op_sw
    } opcode_t;

    typedef enum logic [1:0] {
        cls_int,
        cls_branch,
        cls_load,
        cls_store
    } op_class_t;

    // picks the execution unit and the rob bookkeeping
    function automatic op_class_t op_class(input opcode_t op);
        case (op)
            op_beq, op_bne: return cls_branch;
            op_lw:          return cls_load;
            op_sw:          return cls_store;
            default:        return cls_int;
        endcase
    endfunction

endpackage
